// File: verilog/cnc_pkg.sv
`default_nettype none

package cnc_pkg;

  ////////////////////////////////////////
  // Port and ID widths
  ////////////////////////////////////////

  localparam int unsigned NUM_PORTS  = 4;
  localparam int unsigned PORT_IDX_W = 2;
  localparam int unsigned ID_W       = 2;
  localparam int unsigned MUX_ID_W   = PORT_IDX_W + ID_W;
  localparam int unsigned DS_ID_W    = 2;

  // Remap table limits
  localparam int unsigned NUM_UNIQ_IDS    = 4;
  localparam int unsigned MAX_TXNS_PER_ID = 4;
  localparam int unsigned CNT_W           = 3;

  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;

  // Wide ID after the arbiter, seen as a flat tag or split by port
  typedef union packed {
    logic [MUX_ID_W-1:0] tag;
    struct packed {
      logic [PORT_IDX_W-1:0] port;  // Issuing upstream port
      logic [ID_W-1:0]       id;    // Original upstream ID
    } fields;
  } mux_id_u;

endpackage

`default_nettype wire

// File: verilog/txn_if.sv
`default_nettype none

interface txn_if import cnc_pkg::*; ();

  // Request channel
  logic              req_valid;
  logic              req_ready;
  mux_id_u           req_id;
  logic [ADDR_W-1:0] req_addr;
  logic [DATA_W-1:0] req_wdata;
  logic              req_write;

  // Response channel, ID already restored to the wide tag
  logic              rsp_valid;
  logic              rsp_ready;
  mux_id_u           rsp_id;
  logic [DATA_W-1:0] rsp_rdata;

  modport mgr (
    output req_valid, req_id, req_addr, req_wdata, req_write, rsp_ready,
    input  req_ready, rsp_valid, rsp_id, rsp_rdata
  );

  modport sub (
    input  req_valid, req_id, req_addr, req_wdata, req_write, rsp_ready,
    output req_ready, rsp_valid, rsp_id, rsp_rdata
  );

endinterface

`default_nettype wire

// File: verilog/req_arbiter.sv
`default_nettype none

module req_arbiter import cnc_pkg::*; (
  input  logic                                periph_clk,
  input  logic                                rst_i,
  // Upstream requests
  input  logic [NUM_PORTS-1:0]                up_req_valid_i,
  input  logic [NUM_PORTS-1:0][ID_W-1:0]      up_req_id_i,
  input  logic [NUM_PORTS-1:0][ADDR_W-1:0]    up_req_addr_i,
  input  logic [NUM_PORTS-1:0][DATA_W-1:0]    up_req_wdata_i,
  input  logic [NUM_PORTS-1:0]                up_req_write_i,
  output logic [NUM_PORTS-1:0]                up_req_ready_o,
  // Upstream responses
  output logic [NUM_PORTS-1:0]                up_rsp_valid_o,
  output logic [NUM_PORTS-1:0][ID_W-1:0]      up_rsp_id_o,
  output logic [NUM_PORTS-1:0][DATA_W-1:0]    up_rsp_rdata_o,
  input  logic [NUM_PORTS-1:0]                up_rsp_ready_i,
  txn_if.mgr                                  ds
);

  logic [PORT_IDX_W-1:0] rr_ptr_q;    // Highest priority port
  logic                  lock_q;
  logic [PORT_IDX_W-1:0] lock_idx_q;
  logic                  pick_found;
  logic [PORT_IDX_W-1:0] pick_idx;
  logic [PORT_IDX_W-1:0] sel_idx;
  logic                  req_fire;
  mux_id_u               req_tag;
  mux_id_u               rsp_tag;

  ////////////////////////////////////////
  // Request arbitration
  ////////////////////////////////////////

  // First requester at or after the pointer
  always_comb begin
    logic [PORT_IDX_W-1:0] cand;
    pick_found = 1'b0;
    pick_idx   = '0;
    for (int k = 0; k < NUM_PORTS; k++) begin
      cand = rr_ptr_q + PORT_IDX_W'(k);
      if (!pick_found && up_req_valid_i[cand]) begin
        pick_found = 1'b1;
        pick_idx   = cand;
      end
    end
  end

  assign sel_idx      = lock_q ? lock_idx_q : pick_idx;
  assign ds.req_valid = lock_q ? up_req_valid_i[lock_idx_q] : pick_found;
  assign req_fire     = ds.req_valid && ds.req_ready;

  assign req_tag.fields.port = sel_idx;
  assign req_tag.fields.id   = up_req_id_i[sel_idx];

  assign ds.req_id    = req_tag;
  assign ds.req_addr  = up_req_addr_i[sel_idx];
  assign ds.req_wdata = up_req_wdata_i[sel_idx];
  assign ds.req_write = up_req_write_i[sel_idx];

  always_comb begin
    for (int p = 0; p < NUM_PORTS; p++) begin
      up_req_ready_o[p] = ds.req_valid && (sel_idx == PORT_IDX_W'(p)) && ds.req_ready;
    end
  end

  // Hold the grant while the request is back-pressured
  always_ff @(posedge periph_clk) begin
    if (rst_i) begin
      rr_ptr_q   <= '0;
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else if (req_fire) begin
      rr_ptr_q <= sel_idx + 1'b1;
      lock_q   <= 1'b0;
    end else if (ds.req_valid) begin
      lock_q     <= 1'b1;
      lock_idx_q <= sel_idx;
    end
  end

  ////////////////////////////////////////
  // Response routing
  ////////////////////////////////////////

  assign rsp_tag      = ds.rsp_id;
  assign ds.rsp_ready = up_rsp_ready_i[rsp_tag.fields.port];

  always_comb begin
    for (int p = 0; p < NUM_PORTS; p++) begin
      up_rsp_valid_o[p] = ds.rsp_valid && (rsp_tag.fields.port == PORT_IDX_W'(p));
      up_rsp_id_o[p]    = rsp_tag.fields.id;
      up_rsp_rdata_o[p] = ds.rsp_rdata;
    end
  end

endmodule

`default_nettype wire

// File: verilog/id_remap.sv
`default_nettype none

module id_remap import cnc_pkg::*; (
  input  logic               periph_clk,
  input  logic               rst_i,
  txn_if.sub                 up,
  // Downstream request
  output logic               ds_req_valid_o,
  output logic [DS_ID_W-1:0] ds_req_id_o,
  output logic [ADDR_W-1:0]  ds_req_addr_o,
  output logic [DATA_W-1:0]  ds_req_wdata_o,
  output logic               ds_req_write_o,
  input  logic               ds_req_ready_i,
  // Downstream response
  input  logic               ds_rsp_valid_i,
  input  logic [DS_ID_W-1:0] ds_rsp_id_i,
  input  logic [DATA_W-1:0]  ds_rsp_rdata_i,
  output logic               ds_rsp_ready_o
);

  // Remap table
  logic             ent_valid_q [NUM_UNIQ_IDS];
  mux_id_u          ent_tag_q   [NUM_UNIQ_IDS];
  logic [CNT_W-1:0] ent_cnt_q   [NUM_UNIQ_IDS];

  logic               match_found;
  logic [DS_ID_W-1:0] match_idx;
  logic               free_found;
  logic [DS_ID_W-1:0] free_idx;
  logic [DS_ID_W-1:0] alloc_idx;
  logic               hold_q;      // Offered request still waiting downstream
  logic [DS_ID_W-1:0] hold_idx_q;
  logic               can_accept;
  logic               req_fire;
  logic               rsp_fire;

  ////////////////////////////////////////
  // Lookup and allocation
  ////////////////////////////////////////

  always_comb begin
    match_found = 1'b0;
    match_idx   = '0;
    free_found  = 1'b0;
    free_idx    = '0;
    for (int i = 0; i < NUM_UNIQ_IDS; i++) begin
      if (!match_found && ent_valid_q[i] && (ent_tag_q[i].tag == up.req_id.tag)) begin
        match_found = 1'b1;
        match_idx   = DS_ID_W'(i);
      end
      if (!free_found && !ent_valid_q[i]) begin  // Lowest free entry
        free_found = 1'b1;
        free_idx   = DS_ID_W'(i);
      end
    end
  end

  // A back-pressured request keeps its downstream ID
  assign alloc_idx  = hold_q      ? hold_idx_q :
                      match_found ? match_idx  : free_idx;

  // Stall on a full entry or a full table
  assign can_accept = match_found ? (ent_cnt_q[match_idx] != CNT_W'(MAX_TXNS_PER_ID))
                                  : free_found;

  assign ds_req_valid_o = up.req_valid && can_accept;
  assign up.req_ready   = ds_req_ready_i && can_accept;
  assign ds_req_id_o    = alloc_idx;
  assign ds_req_addr_o  = up.req_addr;
  assign ds_req_wdata_o = up.req_wdata;
  assign ds_req_write_o = up.req_write;

  assign req_fire = ds_req_valid_o && ds_req_ready_i;

  always_ff @(posedge periph_clk) begin
    if (rst_i) begin
      hold_q     <= 1'b0;
      hold_idx_q <= '0;
    end else begin
      hold_q     <= ds_req_valid_o && !ds_req_ready_i;
      hold_idx_q <= alloc_idx;
    end
  end

  ////////////////////////////////////////
  // Response path
  ////////////////////////////////////////

  // Downstream ID is the table index
  assign up.rsp_valid    = ds_rsp_valid_i;
  assign up.rsp_id       = ent_tag_q[ds_rsp_id_i];
  assign up.rsp_rdata    = ds_rsp_rdata_i;
  assign ds_rsp_ready_o  = up.rsp_ready;

  assign rsp_fire = ds_rsp_valid_i && up.rsp_ready;

  ////////////////////////////////////////
  // Entry state
  ////////////////////////////////////////

  for (genvar g = 0; g < NUM_UNIQ_IDS; g++) begin : gen_entry
    logic             inc;
    logic             dec;
    logic [CNT_W-1:0] cnt_d;

    assign inc = req_fire && (alloc_idx == DS_ID_W'(g));
    assign dec = rsp_fire && (ds_rsp_id_i == DS_ID_W'(g));

    // Same-cycle issue and return cancel out
    always_comb begin
      cnt_d = ent_cnt_q[g];
      if (inc && !dec) begin
        cnt_d = ent_cnt_q[g] + 1'b1;
      end else if (dec && !inc) begin
        cnt_d = ent_cnt_q[g] - 1'b1;
      end
    end

    always_ff @(posedge periph_clk) begin
      if (rst_i) begin
        ent_valid_q[g] <= 1'b0;
        ent_cnt_q[g]   <= '0;
      end else begin
        ent_valid_q[g] <= (cnt_d != '0);  // Frees at zero
        ent_cnt_q[g]   <= cnt_d;
      end
    end

    always_ff @(posedge periph_clk) begin
      if (inc && !ent_valid_q[g]) begin
        ent_tag_q[g] <= up.req_id;
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/port_concentrator.sv
`default_nettype none

module port_concentrator import cnc_pkg::*; (
  input  logic                                periph_clk,
  input  logic                                rst_i,
  // Upstream requests
  input  logic [NUM_PORTS-1:0]                up_req_valid_i,
  input  logic [NUM_PORTS-1:0][ID_W-1:0]      up_req_id_i,
  input  logic [NUM_PORTS-1:0][ADDR_W-1:0]    up_req_addr_i,
  input  logic [NUM_PORTS-1:0][DATA_W-1:0]    up_req_wdata_i,
  input  logic [NUM_PORTS-1:0]                up_req_write_i,
  output logic [NUM_PORTS-1:0]                up_req_ready_o,
  // Upstream responses
  output logic [NUM_PORTS-1:0]                up_rsp_valid_o,
  output logic [NUM_PORTS-1:0][ID_W-1:0]      up_rsp_id_o,
  output logic [NUM_PORTS-1:0][DATA_W-1:0]    up_rsp_rdata_o,
  input  logic [NUM_PORTS-1:0]                up_rsp_ready_i,
  // Downstream request
  output logic                                ds_req_valid_o,
  output logic [DS_ID_W-1:0]                  ds_req_id_o,
  output logic [ADDR_W-1:0]                   ds_req_addr_o,
  output logic [DATA_W-1:0]                   ds_req_wdata_o,
  output logic                                ds_req_write_o,
  input  logic                                ds_req_ready_i,
  // Downstream response
  input  logic                                ds_rsp_valid_i,
  input  logic [DS_ID_W-1:0]                  ds_rsp_id_i,
  input  logic [DATA_W-1:0]                   ds_rsp_rdata_i,
  output logic                                ds_rsp_ready_o
);

  txn_if mux_txn ();  // Wide-ID link between arbiter and remapper

  req_arbiter u_req_arbiter (
    .periph_clk     ( periph_clk     ),
    .rst_i          ( rst_i          ),
    .up_req_valid_i ( up_req_valid_i ),
    .up_req_id_i    ( up_req_id_i    ),
    .up_req_addr_i  ( up_req_addr_i  ),
    .up_req_wdata_i ( up_req_wdata_i ),
    .up_req_write_i ( up_req_write_i ),
    .up_req_ready_o ( up_req_ready_o ),
    .up_rsp_valid_o ( up_rsp_valid_o ),
    .up_rsp_id_o    ( up_rsp_id_o    ),
    .up_rsp_rdata_o ( up_rsp_rdata_o ),
    .up_rsp_ready_i ( up_rsp_ready_i ),
    .ds             ( mux_txn.mgr    )
  );

  // Narrows the tagged ID for the downstream port
  id_remap u_id_remap (
    .periph_clk     ( periph_clk     ),
    .rst_i          ( rst_i          ),
    .up             ( mux_txn.sub    ),
    .ds_req_valid_o ( ds_req_valid_o ),
    .ds_req_id_o    ( ds_req_id_o    ),
    .ds_req_addr_o  ( ds_req_addr_o  ),
    .ds_req_wdata_o ( ds_req_wdata_o ),
    .ds_req_write_o ( ds_req_write_o ),
    .ds_req_ready_i ( ds_req_ready_i ),
    .ds_rsp_valid_i ( ds_rsp_valid_i ),
    .ds_rsp_id_i    ( ds_rsp_id_i    ),
    .ds_rsp_rdata_i ( ds_rsp_rdata_i ),
    .ds_rsp_ready_o ( ds_rsp_ready_o )
  );

endmodule

`default_nettype wire

// File: verification/downstream_model.sv
`default_nettype none

module downstream_model import cnc_pkg::*; (
  input  logic               periph_clk,
  input  logic               rst_i,
  input  logic               ds_req_valid_i,
  input  logic [DS_ID_W-1:0] ds_req_id_i,
  input  logic [ADDR_W-1:0]  ds_req_addr_i,
  output logic               ds_req_ready_o = 1'b0,
  output logic               ds_rsp_valid_o = 1'b0,
  output logic [DS_ID_W-1:0] ds_rsp_id_o    = '0,
  output logic [DATA_W-1:0]  ds_rsp_rdata_o = '0,
  input  logic               ds_rsp_ready_i
);
  timeunit 1ns;
  timeprecision 1ps;

  // Accepted requests as {downstream ID, response data}, oldest first
  logic [DS_ID_W+DATA_W-1:0] pend_q [$];

  always @(posedge periph_clk) begin
    int unsigned pick;
    int unsigned sel;
    logic        busy;
    if (rst_i) begin
      pend_q.delete();
      ds_req_ready_o <= 1'b0;
      ds_rsp_valid_o <= 1'b0;
    end else begin
      busy = ds_rsp_valid_o;
      if (ds_req_valid_i && ds_req_ready_o) begin
        pend_q.push_back({ds_req_id_i, ~ds_req_addr_i});  // Data is the inverted address
      end
      if (ds_rsp_valid_o && ds_rsp_ready_i) begin
        busy = 1'b0;
        ds_rsp_valid_o <= 1'b0;
      end
      // Oldest entry of a random ID, so order holds only within one ID
      if (!busy && pend_q.size() != 0 && ($urandom % 4) == 0) begin
        pick = $urandom % pend_q.size();
        sel  = 0;
        while (pend_q[sel][DATA_W +: DS_ID_W] != pend_q[pick][DATA_W +: DS_ID_W]) begin
          sel++;
        end
        {ds_rsp_id_o, ds_rsp_rdata_o} <= pend_q[sel];
        ds_rsp_valid_o <= 1'b1;
        pend_q.delete(sel);
      end
      ds_req_ready_o <= ($urandom % 4) != 0;
    end
  end

endmodule

`default_nettype wire

// File: verification/tb_port_concentrator.sv
`default_nettype none

module tb_port_concentrator import cnc_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned TXNS_PER_PORT  = 150;
  localparam int unsigned NUM_TXNS       = NUM_PORTS * TXNS_PER_PORT;
  localparam int unsigned CYCLES_PER_TXN = 40;
  localparam int unsigned CLK_PERIOD     = 10;

  logic                             periph_clk   = 1'b0;
  logic                             rst_i        = 1'b1;
  logic [NUM_PORTS-1:0]             up_req_valid = '0;
  logic [NUM_PORTS-1:0][ID_W-1:0]   up_req_id    = '0;
  logic [NUM_PORTS-1:0][ADDR_W-1:0] up_req_addr  = '0;
  logic [NUM_PORTS-1:0][DATA_W-1:0] up_req_wdata = '0;
  logic [NUM_PORTS-1:0]             up_req_write = '0;
  logic [NUM_PORTS-1:0]             up_req_ready;
  logic [NUM_PORTS-1:0]             up_rsp_valid;
  logic [NUM_PORTS-1:0][ID_W-1:0]   up_rsp_id;
  logic [NUM_PORTS-1:0][DATA_W-1:0] up_rsp_rdata;
  logic [NUM_PORTS-1:0]             up_rsp_ready = '1;
  logic                             ds_req_valid;
  logic [DS_ID_W-1:0]               ds_req_id;
  logic [ADDR_W-1:0]                ds_req_addr;
  logic [DATA_W-1:0]                ds_req_wdata;
  logic                             ds_req_write;
  logic                             ds_req_ready;
  logic                             ds_rsp_valid;
  logic [DS_ID_W-1:0]               ds_rsp_id;
  logic [DATA_W-1:0]                ds_rsp_rdata;
  logic                             ds_rsp_ready;

  logic [MUX_ID_W+ADDR_W-1:0] issued_q [$];  // {tag, addr} in issue order
  logic [MUX_ID_W-1:0]        ds_tag [NUM_UNIQ_IDS];
  int                         ds_cnt [NUM_UNIQ_IDS];
  int                         passed_over [NUM_PORTS];
  int                         rsp_done = 0;
  int                         errors   = 0;
  int                         checks   = 0;

  always #(CLK_PERIOD / 2) periph_clk = ~periph_clk;

  port_concentrator port_concentrator_i (
    .periph_clk     ( periph_clk   ),
    .rst_i          ( rst_i        ),
    .up_req_valid_i ( up_req_valid ),
    .up_req_id_i    ( up_req_id    ),
    .up_req_addr_i  ( up_req_addr  ),
    .up_req_wdata_i ( up_req_wdata ),
    .up_req_write_i ( up_req_write ),
    .up_req_ready_o ( up_req_ready ),
    .up_rsp_valid_o ( up_rsp_valid ),
    .up_rsp_id_o    ( up_rsp_id    ),
    .up_rsp_rdata_o ( up_rsp_rdata ),
    .up_rsp_ready_i ( up_rsp_ready ),
    .ds_req_valid_o ( ds_req_valid ),
    .ds_req_id_o    ( ds_req_id    ),
    .ds_req_addr_o  ( ds_req_addr  ),
    .ds_req_wdata_o ( ds_req_wdata ),
    .ds_req_write_o ( ds_req_write ),
    .ds_req_ready_i ( ds_req_ready ),
    .ds_rsp_valid_i ( ds_rsp_valid ),
    .ds_rsp_id_i    ( ds_rsp_id    ),
    .ds_rsp_rdata_i ( ds_rsp_rdata ),
    .ds_rsp_ready_o ( ds_rsp_ready )
  );

  downstream_model ds_model (
    .periph_clk     ( periph_clk   ),
    .rst_i          ( rst_i        ),
    .ds_req_valid_i ( ds_req_valid ),
    .ds_req_id_i    ( ds_req_id    ),
    .ds_req_addr_i  ( ds_req_addr  ),
    .ds_req_ready_o ( ds_req_ready ),
    .ds_rsp_valid_o ( ds_rsp_valid ),
    .ds_rsp_id_o    ( ds_rsp_id    ),
    .ds_rsp_rdata_o ( ds_rsp_rdata ),
    .ds_rsp_ready_i ( ds_rsp_ready )
  );

  task automatic compare_value(input string name, input logic [ADDR_W-1:0] got,
                               input logic [ADDR_W-1:0] exp);
    assert (got === exp) checks++;
    else begin
      errors++;
      $display("FAIL %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_rule(input bit ok, input string what);
    assert (ok) checks++;
    else begin
      errors++;
      $display("Error: %s", what);
    end
  endtask

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  for (genvar g = 0; g < NUM_PORTS; g++) begin : gen_port
    initial begin
      int unsigned gap;
      wait (!rst_i);
      @(posedge periph_clk);
      for (int n = 0; n < TXNS_PER_PORT; n++) begin
        up_req_valid[g] <= 1'b1;
        up_req_id[g]    <= (n < TXNS_PER_PORT / 4) ? ID_W'(0) : ID_W'($urandom);  // Repeats first
        up_req_addr[g]  <= {8'(g), 8'(n), 16'($urandom)};
        up_req_wdata[g] <= $urandom;
        up_req_write[g] <= 1'($urandom);
        do @(posedge periph_clk); while (!up_req_ready[g]);
        gap = $urandom % 3;
        if (gap != 0) begin
          up_req_valid[g] <= 1'b0;
          repeat (gap) @(posedge periph_clk);
        end
      end
      up_req_valid[g] <= 1'b0;
    end
  end

  always @(posedge periph_clk) begin
    up_rsp_ready <= NUM_PORTS'($urandom);
  end

  assert property (@(posedge periph_clk) disable iff (rst_i)
    ds_req_valid && !ds_req_ready |=> ds_req_valid && $stable(ds_req_id)
      && $stable(ds_req_addr) && $stable(ds_req_wdata) && $stable(ds_req_write))
  else begin
    errors++;
    $display("Error: downstream request changed before its transfer");
  end

  ////////////////////////////////////////
  // Scoreboard
  ////////////////////////////////////////

  always @(posedge periph_clk) begin
    logic [MUX_ID_W-1:0] tag;
    logic [ADDR_W-1:0]   addr;
    logic [DATA_W-1:0]   wdata;
    logic                wr;
    int                  live;
    bit                  known;
    int                  hit;
    if (!rst_i) begin
      if (ds_req_valid && ds_req_ready) begin
        tag   = '0;
        addr  = '0;
        wdata = '0;
        wr    = 1'b0;
        for (int p = 0; p < NUM_PORTS; p++) begin
          if (up_req_ready[p]) begin
            tag   = {PORT_IDX_W'(p), up_req_id[p]};  // Port index above the original ID
            addr  = up_req_addr[p];
            wdata = up_req_wdata[p];
            wr    = up_req_write[p];
          end
        end
        check_rule($countones(up_req_ready) == 1, "downstream issue without exactly one grant");
        compare_value("ds_req_addr_o", ds_req_addr, addr);
        compare_value("ds_req_wdata_o", ADDR_W'(ds_req_wdata), ADDR_W'(wdata));
        compare_value("ds_req_write_o", ADDR_W'(ds_req_write), ADDR_W'(wr));
        live  = 0;
        known = 1'b0;
        for (int d = 0; d < NUM_UNIQ_IDS; d++) begin
          if (ds_cnt[d] != 0) begin
            live++;
            known = known || (ds_tag[d] == tag);
            check_rule(ds_tag[d] != tag || d == int'(ds_req_id), "tag on two downstream IDs");
          end
        end
        check_rule(known || live < NUM_UNIQ_IDS, "new tag issued with the remap table full");
        if (ds_cnt[ds_req_id] != 0) begin
          compare_value("ds_req_id_o tag", ADDR_W'(ds_tag[ds_req_id]), ADDR_W'(tag));
          check_rule(ds_cnt[ds_req_id] < MAX_TXNS_PER_ID, "tag issued beyond its limit");
        end
        ds_tag[ds_req_id] = tag;
        ds_cnt[ds_req_id]++;
        issued_q.push_back({tag, addr});
      end else begin
        check_rule(up_req_ready == '0, "upstream request taken without a downstream issue");
      end

      if (ds_rsp_valid && ds_rsp_ready) begin
        check_rule(ds_cnt[ds_rsp_id] != 0, "response for an idle downstream ID");
        ds_cnt[ds_rsp_id]--;
      end
      check_rule($countones(up_rsp_valid & up_rsp_ready)
                   == ((ds_rsp_valid && ds_rsp_ready) ? 1 : 0),
                 "response lost or duplicated on its way upstream");

      for (int p = 0; p < NUM_PORTS; p++) begin
        if (up_rsp_valid[p] && up_rsp_ready[p]) begin
          hit = -1;
          for (int i = issued_q.size() - 1; i >= 0; i--) begin
            if (issued_q[i][ADDR_W +: MUX_ID_W] == {PORT_IDX_W'(p), up_rsp_id[p]}) begin
              hit = i;  // Oldest match wins
            end
          end
          check_rule(hit >= 0, "response on a port with no matching request");
          if (hit >= 0) begin
            compare_value("up_rsp_rdata_o", up_rsp_rdata[p], ~issued_q[hit][ADDR_W-1:0]);
            issued_q.delete(hit);
          end
          rsp_done++;
        end
        // Grants to other ports while this one waits
        if (!up_req_valid[p] || up_req_ready[p]) begin
          passed_over[p] = 0;
        end else if (up_req_ready != '0) begin
          passed_over[p]++;
        end
        check_rule(passed_over[p] < NUM_PORTS, "port passed over by too many grants");
      end
    end
  end

  initial begin
    void'($urandom(74));
    repeat (4) @(posedge periph_clk);
    rst_i <= 1'b0;
    wait (rsp_done == NUM_TXNS);
    repeat (10) @(posedge periph_clk);
    check_rule(issued_q.size() == 0, "requests left without a response");
    $display("Closing report: %0d errors in %0d checks", errors, checks);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin
    #(NUM_TXNS * CYCLES_PER_TXN * CLK_PERIOD);
    $display("Error: timeout with %0d of %0d responses returned", rsp_done, NUM_TXNS);
    $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: compile.f
verilog/cnc_pkg.sv
verilog/txn_if.sv
verilog/req_arbiter.sv
verilog/id_remap.sv
verilog/port_concentrator.sv
verification/downstream_model.sv
verification/tb_port_concentrator.sv

// File: Bender.yml
package:
  name: port_concentrator

sources:
  - verilog/cnc_pkg.sv
  - verilog/txn_if.sv
  - verilog/req_arbiter.sv
  - verilog/id_remap.sv
  - verilog/port_concentrator.sv
  - target: test
    files:
      - verification/downstream_model.sv
      - verification/tb_port_concentrator.sv
